// ==== build.f ====
+incdir+src
src/bpu_pkg.sv
src/fetch_predict.sv
src/bpu_table.sv
src/return_stack.sv
src/resolve_unit.sv
src/bpu_top.sv
dv/bpu_tb.sv

// ==== Makefile ====
SIM      := verilator
TOP      := bpu_tb
FILELIST := build.f
FLAGS    := --binary --assert -j 0
BUILD    := obj_dir
LOG      := sim.log

SRCS := $(shell grep -v '^+' $(FILELIST)) src/bpu_cfg.svh

.PHONY: all compile run clean

all: run

compile: $(BUILD)/V$(TOP)

$(BUILD)/V$(TOP): $(FILELIST) $(SRCS)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: compile
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q '^STATUS: PASS$$' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== dv/bpu_tb.sv ====
// branch prediction unit testbench checking a model of table, stack and counters
`timescale 1ns/1ps
`include "bpu_cfg.svh"

module bpu_tb
  import bpu_pkg::*;
();

  // tests need about 130 cycles
  localparam int timeout_cycles = 2000;

  logic        clk;
  logic        reset;
  logic [31:0] pc;
  logic [31:0] next_pc;
  logic [3:0]  pc_valid;
  logic [3:0]  pc_is_jump;
  logic        es_valid1;
  logic        in_excp1;
  logic        is_etrn1;
  logic [31:0] es_pc1;
  logic        taken1;
  logic        pre_fail1;
  logic [31:0] right_target1;
  jump_type_e  jump_type1;
  logic        es_valid2;
  logic        in_excp2;
  logic        is_etrn2;
  logic [31:0] es_pc2;
  logic        taken2;
  logic        pre_fail2;
  logic [31:0] right_target2;
  jump_type_e  jump_type2;
  logic [15:0] branch_count;
  logic [15:0] hit_count;

  // model state
  bit                    m_valid [`BPU_SIZE];
  logic [1:0]            m_pht [`BPU_SIZE];
  logic [`BPU_TAG_W-1:0] m_tag [`BPU_SIZE];
  jump_type_e            m_jt [`BPU_SIZE];
  logic [29:0]           m_tgt [`BPU_SIZE];
  logic [29:0]           m_ras [$];
  bit                    m_pred_ret;
  int                    m_branches;
  int                    m_hits;

  // resolve request for the next training cycle with index 0 as port 1
  bit          r_vld [2];
  bit          r_excp [2];
  bit          r_etrn [2];
  logic [31:0] r_pc [2];
  bit          r_taken [2];
  bit          r_fail [2];
  logic [31:0] r_tgt [2];
  jump_type_e  r_jt [2];

  int seed;
  int cycle_count;
  int check_count;
  int error_count;
  int test_count;
  int test_mark;

  bpu_top dut_i (.*);

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial
  begin
    cycle_count = 0;
    while (cycle_count < timeout_cycles)
    begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: run did not finish within %0d cycles", timeout_cycles);
    $display("STATUS: FAIL");
    $finish;
  end

  task automatic check_value(string name, string what, logic [31:0] exp, logic [31:0] act);
    check_count++;
    assert (act === exp)
    else
    begin
      $display("[FAIL] %s %s expected %h actual %h", name, what, exp, act);
      error_count++;
    end
  endtask

  function automatic void set_port(int p, logic [31:0] addr, bit tk, logic [31:0] tgt,
                                   jump_type_e jt);
    r_vld[p]   = 1'b1;
    r_excp[p]  = 1'b0;
    r_etrn[p]  = 1'b0;
    r_fail[p]  = 1'b0;
    r_pc[p]    = addr;
    r_taken[p] = tk;
    r_tgt[p]   = tgt;
    r_jt[p]    = jt;
  endfunction

  function automatic void store_entry(int p, logic [8:0] i);
    m_tag[i] = r_pc[p][31:11];
    m_jt[i]  = r_jt[p];
    m_tgt[i] = r_tgt[p][31:2];
  endfunction

  // one cycle on both resolve ports with the model trained from pre-edge state
  task automatic resolve_cycle();
    bit          act [2];
    bit          hit [2];
    logic [1:0]  old [2];
    logic [8:0]  idx [2];
    bit          do_push;
    bit          do_pop;
    logic [29:0] ret_addr;
    @(posedge clk);
    es_valid1     <= r_vld[0];
    in_excp1      <= r_excp[0];
    is_etrn1      <= r_etrn[0];
    es_pc1        <= r_pc[0];
    taken1        <= r_taken[0];
    pre_fail1     <= r_fail[0];
    right_target1 <= r_tgt[0];
    jump_type1    <= r_jt[0];
    es_valid2     <= r_vld[1];
    in_excp2      <= r_excp[1];
    is_etrn2      <= r_etrn[1];
    es_pc2        <= r_pc[1];
    taken2        <= r_taken[1];
    pre_fail2     <= r_fail[1];
    right_target2 <= r_tgt[1];
    jump_type2    <= r_jt[1];
    do_push  = 1'b0;
    do_pop   = 1'b0;
    ret_addr = '0;
    for (int p = 0; p < 2; p++)
    begin
      idx[p] = r_pc[p][10:2];
      act[p] = r_vld[p] && !r_excp[p] && !r_etrn[p];
      hit[p] = m_valid[idx[p]] && (m_tag[idx[p]] == r_pc[p][31:11]);
      old[p] = m_pht[idx[p]];
    end
    // port 2 applied last, so it owns a shared index
    for (int p = 0; p < 2; p++)
    begin
      if (act[p])
      begin
        m_branches++;
        if (!r_fail[p])
          m_hits++;
        if (r_taken[p] && !hit[p])
        begin
          m_valid[idx[p]] = 1'b1;
          m_pht[idx[p]]   = 2'd2;
          store_entry(p, idx[p]);
        end
        else if (hit[p] && r_taken[p])
        begin
          m_pht[idx[p]] = (old[p] == 2'd3) ? 2'd3 : old[p] + 2'd1;
          store_entry(p, idx[p]);
        end
        else if (hit[p])
          m_pht[idx[p]] = (old[p] == 2'd0) ? 2'd0 : old[p] - 2'd1;
        if (r_taken[p] && (r_jt[p] == jt_call))
        begin
          do_push  = 1'b1;
          ret_addr = 30'((r_pc[p] + 32'd4) >> 2);
        end
        if (r_taken[p] && (r_jt[p] == jt_ret))
          do_pop = 1'b1;
      end
    end
    if (do_push)
      m_ras.push_back(ret_addr);
    else if (do_pop)
      void'(m_ras.pop_back());
    @(posedge clk);
    es_valid1 <= 1'b0;
    es_valid2 <= 1'b0;
    r_vld[0] = 1'b0;
    r_vld[1] = 1'b0;
  endtask

  // expected prediction from the model compared with the dut outputs
  task automatic check_lookup(string name, logic [31:0] addr);
    logic [3:0]  exp_valid;
    logic [3:0]  exp_jump;
    logic [31:0] exp_next;
    logic [8:0]  i;
    bit          found;
    bit          is_ret;
    exp_jump = 4'b0000;
    exp_next = {addr[31:4], 4'b0000} + 32'd16;
    found    = 1'b0;
    is_ret   = 1'b0;
    for (int s = 0; s < 4; s++)
      exp_valid[s] = (s >= int'(addr[3:2]));
    for (int s = 0; s < 4; s++)
    begin
      i = {addr[10:4], 2'(s)};
      if (!found && exp_valid[s] && m_valid[i] && (m_tag[i] == addr[31:11]) &&
          (m_pht[i] >= 2'd2))
      begin
        found       = 1'b1;
        exp_jump[s] = 1'b1;
        for (int k = s + 1; k < 4; k++)
          exp_valid[k] = 1'b0;
        is_ret   = (m_jt[i] == jt_ret);
        exp_next = is_ret ? {m_ras[$], 2'b00} : {m_tgt[i], 2'b00};
      end
    end
    @(posedge clk);
    pc <= addr;
    @(negedge clk);
    check_value(name, "next_pc", exp_next, next_pc);
    check_value(name, "pc_valid", 32'(exp_valid), 32'(pc_valid));
    check_value(name, "pc_is_jump", 32'(exp_jump), 32'(pc_is_jump));
    // predicted return leaves the stack once fetch moves on
    if (m_pred_ret && !is_ret)
      void'(m_ras.pop_back());
    m_pred_ret = is_ret;
  endtask

  task automatic finish_test(string name);
    test_count++;
    $display("test %-20s %s", name, (error_count == test_mark) ? "ok" : "failed");
    test_mark = error_count;
  endtask

  task automatic reset_fallthrough();
    for (int n = 0; n < 20; n++)
      check_lookup("reset_fallthrough", $random(seed));
    finish_test("reset_fallthrough");
  endtask

  task automatic cond_allocate();
    set_port(0, 32'h0001_2344, 1'b1, 32'h0001_8000, jt_cond);
    resolve_cycle();
    check_lookup("cond_allocate", 32'h0001_2340);
    check_lookup("cond_allocate", 32'h0001_2348);
    finish_test("cond_allocate");
  endtask

  task automatic counter_saturation();
    // three taken, three not taken, then two taken
    for (int n = 0; n < 8; n++)
    begin
      set_port(0, 32'h0000_5008, (n < 3) || (n >= 6), 32'h0000_6000, jt_cond);
      resolve_cycle();
      check_lookup("counter_saturation", 32'h0000_5000);
    end
    finish_test("counter_saturation");
  endtask

  task automatic tag_replace();
    set_port(0, 32'h0002_2344, 1'b1, 32'h0002_0000, jt_cond);
    resolve_cycle();
    check_lookup("tag_replace", 32'h0001_2340);
    check_lookup("tag_replace", 32'h0002_2340);
    finish_test("tag_replace");
  endtask

  task automatic dual_port();
    set_port(0, 32'h0003_0100, 1'b1, 32'h0004_0000, jt_call);
    set_port(1, 32'h0004_020c, 1'b1, 32'h0003_0104, jt_ret);
    resolve_cycle();
    check_lookup("dual_port", 32'h0004_0200);
    check_lookup("dual_port", 32'h0003_0100);
    // same index on both ports as a miss and then a hit
    for (int n = 0; n < 2; n++)
    begin
      set_port(0, 32'h0005_0010, 1'b1, 32'h0005_1000 + 32'(n) * 32'h2000, jt_cond);
      set_port(1, 32'h0005_0010, 1'b1, 32'h0005_2000 + 32'(n) * 32'h2000, jt_cond);
      resolve_cycle();
      check_lookup("dual_port", 32'h0005_0010);
    end
    finish_test("dual_port");
  endtask

  task automatic perf_counters();
    for (int n = 0; n < 24; n++)
    begin
      for (int p = 0; p < 2; p++)
      begin
        set_port(p, $random(seed), ($random(seed) & 1) != 0, $random(seed), jt_cond);
        r_vld[p]  = ($random(seed) & 3) != 0;
        r_excp[p] = ($random(seed) & 7) == 0;
        r_etrn[p] = ($random(seed) & 7) == 0;
        r_fail[p] = ($random(seed) & 1) != 0;
      end
      resolve_cycle();
    end
    @(negedge clk);
    check_value("perf_counters", "branch_count", 32'(m_branches), 32'(branch_count));
    check_value("perf_counters", "hit_count", 32'(m_hits), 32'(hit_count));
    finish_test("perf_counters");
  endtask

  initial
  begin
    seed          = 27854;
    check_count   = 0;
    error_count   = 0;
    test_count    = 0;
    test_mark     = 0;
    m_branches    = 0;
    m_hits        = 0;
    m_pred_ret    = 1'b0;
    reset         = 1'b1;
    pc            = '0;
    es_valid1     = 1'b0;
    in_excp1      = 1'b0;
    is_etrn1      = 1'b0;
    es_pc1        = '0;
    taken1        = 1'b0;
    pre_fail1     = 1'b0;
    right_target1 = '0;
    jump_type1    = jt_cond;
    es_valid2     = 1'b0;
    in_excp2      = 1'b0;
    is_etrn2      = 1'b0;
    es_pc2        = '0;
    taken2        = 1'b0;
    pre_fail2     = 1'b0;
    right_target2 = '0;
    jump_type2    = jt_cond;
    for (int i = 0; i < `BPU_SIZE; i++)
      m_valid[i] = 1'b0;
    for (int p = 0; p < 2; p++)
    begin
      set_port(p, '0, 1'b0, '0, jt_cond);
      r_vld[p] = 1'b0;
    end
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    reset_fallthrough();
    cond_allocate();
    counter_saturation();
    tag_replace();
    dual_port();
    perf_counters();
    $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
    if (error_count == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

// ==== src/bpu_top.sv ====
// branch prediction unit top, fetch lookup plus two execute training ports
`timescale 1ns/1ps
`include "bpu_cfg.svh"

module bpu_top
  import bpu_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic [31:0] pc,
  output logic [31:0] next_pc,
  output logic [3:0]  pc_valid,
  output logic [3:0]  pc_is_jump,
  input  logic        es_valid1,
  input  logic        in_excp1,
  input  logic        is_etrn1,
  input  logic [31:0] es_pc1,
  input  logic        taken1,
  input  logic        pre_fail1,
  input  logic [31:0] right_target1,
  input  jump_type_e  jump_type1,
  input  logic        es_valid2,
  input  logic        in_excp2,
  input  logic        is_etrn2,
  input  logic [31:0] es_pc2,
  input  logic        taken2,
  input  logic        pre_fail2,
  input  logic [31:0] right_target2,
  input  jump_type_e  jump_type2,
  output logic [15:0] branch_count,
  output logic [15:0] hit_count
);

  // lookup path
  logic [`BPU_IDX_HI-`BPU_IDX_LO:0] rd_idx;
  logic [`BPU_TAG_W-1:0]            rd_tag;
  btb_entry_t                       rd_entry [4];
  logic [3:0]                       rd_hit;
  logic [29:0]                      top_addr;
  logic                             pred_pop;

  // training path
  logic                             upd_en1;
  logic                             upd_taken1;
  logic [`BPU_IDX_HI-`BPU_IDX_LO:0] upd_idx1;
  logic [`BPU_TAG_W-1:0]            upd_tag1;
  btb_entry_t                       upd_entry1;
  logic                             upd_en2;
  logic                             upd_taken2;
  logic [`BPU_IDX_HI-`BPU_IDX_LO:0] upd_idx2;
  logic [`BPU_TAG_W-1:0]            upd_tag2;
  btb_entry_t                       upd_entry2;
  logic                             push;
  logic [29:0]                      push_addr;
  logic                             res_pop;

  fetch_predict fetch_predict_i (.*);

  bpu_table bpu_table_i (.*);

  return_stack return_stack_i (.*);

  resolve_unit resolve_unit_i (.*);

endmodule

// ==== src/resolve_unit.sv ====
// execute resolve decode: table training strobes, stack requests and branch statistics
`timescale 1ns/1ps
`include "bpu_cfg.svh"

module resolve_unit
  import bpu_pkg::*;
(
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic                                  es_valid1,
  input  logic                                  in_excp1,
  input  logic                                  is_etrn1,
  input  logic [31:0]                           es_pc1,
  input  logic                                  taken1,
  input  logic                                  pre_fail1,
  input  logic [31:0]                           right_target1,
  input  jump_type_e                            jump_type1,
  input  logic                                  es_valid2,
  input  logic                                  in_excp2,
  input  logic                                  is_etrn2,
  input  logic [31:0]                           es_pc2,
  input  logic                                  taken2,
  input  logic                                  pre_fail2,
  input  logic [31:0]                           right_target2,
  input  jump_type_e                            jump_type2,
  output logic                                  upd_en1,
  output logic                                  upd_taken1,
  output logic [`BPU_IDX_HI-`BPU_IDX_LO:0]      upd_idx1,
  output logic [`BPU_TAG_W-1:0]                 upd_tag1,
  output btb_entry_t                            upd_entry1,
  output logic                                  upd_en2,
  output logic                                  upd_taken2,
  output logic [`BPU_IDX_HI-`BPU_IDX_LO:0]      upd_idx2,
  output logic [`BPU_TAG_W-1:0]                 upd_tag2,
  output btb_entry_t                            upd_entry2,
  output logic                                  push,
  output logic [29:0]                           push_addr,
  output logic                                  res_pop,
  output logic [15:0]                           branch_count,
  output logic [15:0]                           hit_count
);

  logic call1;
  logic call2;
  logic ret1;
  logic ret2;

  // exception and exception return cancel training
  assign upd_en1    = es_valid1 && !in_excp1 && !is_etrn1;
  assign upd_en2    = es_valid2 && !in_excp2 && !is_etrn2;
  assign upd_taken1 = taken1;
  assign upd_taken2 = taken2;
  assign upd_idx1   = es_pc1[`BPU_IDX_HI:`BPU_IDX_LO];
  assign upd_idx2   = es_pc2[`BPU_IDX_HI:`BPU_IDX_LO];
  assign upd_tag1   = es_pc1[31:`BPU_IDX_HI+1];
  assign upd_tag2   = es_pc2[31:`BPU_IDX_HI+1];
  assign upd_entry1 = '{jtype: jump_type1, tag: upd_tag1, target: right_target1[31:2]};
  assign upd_entry2 = '{jtype: jump_type2, tag: upd_tag2, target: right_target2[31:2]};

  // taken calls and returns drive the stack
  assign call1 = upd_en1 && taken1 && (jump_type1 == jt_call);
  assign call2 = upd_en2 && taken2 && (jump_type2 == jt_call);
  assign ret1  = upd_en1 && taken1 && (jump_type1 == jt_ret);
  assign ret2  = upd_en2 && taken2 && (jump_type2 == jt_ret);

  assign push      = call1 || call2;
  // port 2 owns the stack when both ports call
  assign push_addr = call2 ? es_pc2[31:2] + 30'd1 : es_pc1[31:2] + 30'd1;
  assign res_pop   = ret1 || ret2;

  always_ff @(posedge clk) begin
    if (reset)
    begin
      branch_count <= '0;
      hit_count    <= '0;
    end
    else
    begin
      branch_count <= branch_count + 16'(upd_en1) + 16'(upd_en2);
      hit_count    <= hit_count + 16'(upd_en1 && !pre_fail1) + 16'(upd_en2 && !pre_fail2);
    end
  end

endmodule

// ==== src/return_stack.sv ====
// return address stack, push from resolve, pop from resolve or on falling predict pop
`timescale 1ns/1ps
`include "bpu_cfg.svh"

module return_stack (
  input  logic        clk,
  input  logic        reset,
  input  logic        push,
  input  logic [29:0] push_addr,
  input  logic        res_pop,
  input  logic        pred_pop,
  output logic [29:0] top_addr
);

  logic [29:0]            entries [`RAS_SIZE];
  // one extra bit so a full stack is distinguishable from an empty one
  logic [`RAS_IDX_W:0]    ptr_q;
  logic [`RAS_IDX_W-1:0]  top_idx;
  logic                   pred_pop_q;
  logic                   pred_pop_fall;
  logic                   do_pop;

  assign top_idx       = ptr_q[`RAS_IDX_W-1:0] - 1'b1;
  assign top_addr      = entries[top_idx];
  // predicted return commits once fetch moves past it
  assign pred_pop_fall = pred_pop_q && !pred_pop;
  assign do_pop        = res_pop || pred_pop_fall;

  always_ff @(posedge clk) begin
    if (reset)
    begin
      ptr_q      <= '0;
      pred_pop_q <= 1'b0;
    end
    else
    begin
      pred_pop_q <= pred_pop;
      // push wins over a pop in the same cycle
      if (push)
      begin
        ptr_q <= ptr_q + 1'b1;
      end
      else if (do_pop)
      begin
        ptr_q <= ptr_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push)
    begin
      entries[ptr_q[`RAS_IDX_W-1:0]] <= push_addr;
    end
  end

  a_no_underflow : assert property (@(posedge clk) disable iff (reset)
    (do_pop && !push) |-> (ptr_q != '0))
    else $error("return stack pop while empty");

  a_no_overflow : assert property (@(posedge clk) disable iff (reset)
    push |-> (ptr_q != (`RAS_IDX_W + 1)'(`RAS_SIZE)))
    else $error("return stack push while full");

endmodule

// ==== src/bpu_table.sv ====
// branch target buffer with 2-bit pattern history, four group reads and two training ports
`timescale 1ns/1ps
`include "bpu_cfg.svh"

module bpu_table
  import bpu_pkg::*;
(
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic [`BPU_IDX_HI-`BPU_IDX_LO:0]      rd_idx,
  input  logic [`BPU_TAG_W-1:0]                 rd_tag,
  input  logic                                  upd_en1,
  input  logic                                  upd_taken1,
  input  logic [`BPU_IDX_HI-`BPU_IDX_LO:0]      upd_idx1,
  input  logic [`BPU_TAG_W-1:0]                 upd_tag1,
  input  btb_entry_t                            upd_entry1,
  input  logic                                  upd_en2,
  input  logic                                  upd_taken2,
  input  logic [`BPU_IDX_HI-`BPU_IDX_LO:0]      upd_idx2,
  input  logic [`BPU_TAG_W-1:0]                 upd_tag2,
  input  btb_entry_t                            upd_entry2,
  output btb_entry_t                            rd_entry [4],
  output logic [3:0]                            rd_hit
);

  localparam int IDX_W = `BPU_IDX_HI - `BPU_IDX_LO + 1;

  logic [`BPU_SIZE-1:0] valid_q;
  logic [1:0]           pht_q [`BPU_SIZE];
  btb_entry_t           btb_q [`BPU_SIZE];

  // training ports gathered so both share one update loop
  logic [1:0]           en;
  logic [1:0]           taken;
  logic [IDX_W-1:0]     idx   [2];
  logic [`BPU_TAG_W-1:0] tag  [2];
  btb_entry_t           entry [2];
  logic [1:0]           ent_hit;
  logic [1:0]           alloc;

  assign en       = {upd_en2, upd_en1};
  assign taken    = {upd_taken2, upd_taken1};
  assign idx[0]   = upd_idx1;
  assign idx[1]   = upd_idx2;
  assign tag[0]   = upd_tag1;
  assign tag[1]   = upd_tag2;
  assign entry[0] = upd_entry1;
  assign entry[1] = upd_entry2;

  // group read, base index has the slot bits cleared
  for (genvar s = 0; s < 4; s++) begin : g_rd
    logic [IDX_W-1:0] slot_idx;

    assign slot_idx    = {rd_idx[IDX_W-1:2], 2'(s)};
    assign rd_entry[s] = btb_q[slot_idx];
    assign rd_hit[s]   = valid_q[slot_idx] && (btb_q[slot_idx].tag == rd_tag) &&
                         (pht_q[slot_idx] >= 2'd2);
  end

  for (genvar p = 0; p < 2; p++) begin : g_port
    assign ent_hit[p] = valid_q[idx[p]] && (btb_q[idx[p]].tag == tag[p]);
    // new taken branch replaces whatever sits at its index
    assign alloc[p]   = en[p] && taken[p] && !ent_hit[p];

    // a ret entry with a zero tag would come from the low 2 KB, never used for returns
    a_ret_tag : assert property (@(posedge clk) disable iff (reset)
      alloc[p] |-> !((entry[p].jtype == jt_ret) && (entry[p].tag == '0)))
      else $error("ret entry allocated with zero tag on port %0d", p + 1);
  end

  always_ff @(posedge clk) begin
    if (reset)
    begin
      valid_q <= '0;
    end
    else
    begin
      for (int p = 0; p < 2; p++)
      begin
        if (alloc[p])
        begin
          valid_q[idx[p]] <= 1'b1;
        end
      end
    end
  end

  // port 2 comes later in the loop, so it wins on a shared index
  always_ff @(posedge clk) begin
    for (int p = 0; p < 2; p++)
    begin
      if (alloc[p])
      begin
        pht_q[idx[p]] <= 2'd2;
        btb_q[idx[p]] <= entry[p];
      end
      else if (en[p] && ent_hit[p])
      begin
        if (taken[p])
        begin
          pht_q[idx[p]] <= (pht_q[idx[p]] == 2'd3) ? 2'd3 : pht_q[idx[p]] + 2'd1;
          btb_q[idx[p]] <= entry[p];
        end
        else
        begin
          pht_q[idx[p]] <= (pht_q[idx[p]] == 2'd0) ? 2'd0 : pht_q[idx[p]] - 2'd1;
        end
      end
    end
  end

endmodule

// ==== src/fetch_predict.sv ====
// fetch group prediction: slot valid mask, first taken slot and next fetch pc
`timescale 1ns/1ps
`include "bpu_cfg.svh"

module fetch_predict
  import bpu_pkg::*;
(
  input  logic [31:0]                       pc,
  input  logic [3:0]                        rd_hit,
  input  btb_entry_t                        rd_entry [4],
  input  logic [29:0]                       top_addr,
  output logic [`BPU_IDX_HI-`BPU_IDX_LO:0]  rd_idx,
  output logic [`BPU_TAG_W-1:0]             rd_tag,
  output logic [31:0]                       next_pc,
  output logic [3:0]                        pc_valid,
  output logic [3:0]                        pc_is_jump,
  output logic                              pred_pop
);

  logic [3:0]  group_valid;
  logic        hit_any;
  logic [1:0]  hit_slot;
  btb_entry_t  sel_entry;

  assign rd_idx = pc[`BPU_IDX_HI:`BPU_IDX_LO];
  assign rd_tag = pc[31:`BPU_IDX_HI+1];

  // slots before the pc offset are not part of this fetch
  assign group_valid = 4'b1111 << pc[3:2];

  // scan high to low so the lowest hitting slot is kept
  always_comb begin
    hit_any  = 1'b0;
    hit_slot = 2'd0;
    for (int s = 3; s >= 0; s--)
    begin
      if (group_valid[s] && rd_hit[s])
      begin
        hit_any  = 1'b1;
        hit_slot = 2'(s);
      end
    end
  end

  assign sel_entry = rd_entry[hit_slot];

  always_comb begin
    if (hit_any)
    begin
      pc_is_jump = 4'b0001 << hit_slot;
      // keep slots up to and including the taken one
      pc_valid   = group_valid & ~(4'b1110 << hit_slot);
      if (sel_entry.jtype == jt_ret)
      begin
        next_pc = {top_addr, 2'b00};
      end
      else
      begin
        next_pc = {sel_entry.target, 2'b00};
      end
    end
    else
    begin
      pc_is_jump = 4'b0000;
      pc_valid   = group_valid;
      next_pc    = {pc[31:4] + 28'd1, 4'b0000};
    end
  end

  assign pred_pop = hit_any && (sel_entry.jtype == jt_ret);

endmodule

// ==== src/bpu_pkg.sv ====
// branch prediction types: jump classification and target buffer entry layout
`include "bpu_cfg.svh"

package bpu_pkg;

  // call pushes the return stack, ret is predicted from its top
  typedef enum logic [1:0] {
    jt_cond   = 2'b00,
    jt_call   = 2'b01,
    jt_ret    = 2'b10,
    jt_direct = 2'b11
  } jump_type_e;

  // 2 + 21 + 30 = 53 bits
  typedef struct packed {
    jump_type_e             jtype;
    logic [`BPU_TAG_W-1:0]  tag;
    logic [29:0]            target;
  } btb_entry_t;

endpackage

// ==== src/bpu_cfg.svh ====
// branch prediction unit sizing: table depth, pc index/tag ranges, return stack depth
`ifndef BPU_CFG_SVH
`define BPU_CFG_SVH

// target buffer depth, one entry per instruction word slot
`define BPU_SIZE 512

// pc bits selecting the table entry
`define BPU_IDX_LO 2
`define BPU_IDX_HI 10

// tag covers pc bits 31 down to BPU_IDX_HI + 1
`define BPU_TAG_W 21

// return address stack
`define RAS_SIZE 8
`define RAS_IDX_W 3

`endif
